/* decodeStage.f */
decodePkg.sv
decodeDest.sv
decodeSrc.sv
decodeImm.sv
decodeStage.sv
decodeStage_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f decodeStage.f \
	--top-module decodeStage_tb -o decodeStageSim
out=$(./obj_dir/decodeStageSim)
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

/* decodeStage_tb.sv */
// Testbench for the decode stage with a reference model and checking assertions

`timescale 1ns/1ps

module decodeStage_tb
	import decodePkg::*;
;

	localparam int DataWidth = 64;
	localparam int TimeoutCycles = 64;

	logic            clk;
	logic            rstN;
	logic            inVld;
	logic            stall;
	operating_mode_t om;
	micro_op_t       instr;
	logic            outVld;
	decoded_t        dec;

	// Expected output register that is loaded on every accepted micro-op
	decoded_t        expDec;
	logic            expVld;
	int              acceptCount = 0;
	int              seenCount = 0;
	int              errCount = 0;
	int              passCount = 0;
	int              failCount = 0;
	int              seed = 32'hbeb9;
	opcode_t         legalOps[$];
	opcode_t         code;
	micro_op_t       uop;
	int              errBefore;
	int              cycles;

	decodeStage #(
		.DataWidth (DataWidth)
	) dut_i (
		.clk    (clk),
		.rstN   (rstN),
		.inVld  (inVld),
		.stall  (stall),
		.om     (om),
		.instr  (instr),
		.outVld (outVld),
		.dec    (dec)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Reference model
	// ========================================================================

	// Decode rules written out per opcode class
	function automatic decoded_t refDecode(input micro_op_t op, input operating_mode_t m);
		decoded_t d;
		opcode_t c;
		bit isAlu;
		bit isFlt;
		bit isLoad;
		bit isStore;
		bit isAtomic;
		bit legal;
		d = '0;
		c = op.opcode;
		isAlu = c inside {OP_ADDI, OP_SUBFI, OP_CMPI, OP_CMPUI, OP_ANDI, OP_ORI, OP_XORI,
			OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_SHIFT};
		isFlt = c inside {OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ};
		isLoad = c inside {OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ,
			OP_LOAD, OP_LOADA, OP_LDV};
		isStore = c inside {OP_STB, OP_STW, OP_STORE};
		isAtomic = c inside {OP_AMO, OP_CMPSWAP};
		legal = isAlu || isFlt || isLoad || isStore || isAtomic ||
			(c inside {OP_CSR, OP_BSR, OP_JSR, OP_NOP});
		d.opcode = c;
		// Everything legal except stores and NOP writes a destination
		if (isAlu || isFlt || isLoad || isAtomic || (c inside {OP_CSR, OP_BSR, OP_JSR}))
		begin
			d.Rd = op.Rd;
			d.Rdv = 1'b1;
		end
		if (isAlu || isFlt || isLoad || isStore || isAtomic || c == OP_JSR)
		begin
			d.Rs1 = op.Rs1;
			d.Rs1v = 1'b1;
		end
		if (isFlt || isStore || isAtomic)
		begin
			d.Rs2 = op.Rs2;
			d.Rs2v = 1'b1;
		end
		if (c inside {OP_ANDI, OP_ORI, OP_XORI, OP_CMPUI, OP_MULUI, OP_DIVUI, OP_CSR})
			d.imm = {44'h0, op.imm};
		else if (c == OP_SHIFT)
			d.imm = {57'h0, op.imm[6:0]};
		else if (legal && c != OP_NOP)
			d.imm = {{44{op.imm[19]}}, op.imm};
		// CSR privilege sits in the top two immediate bits
		d.exc = !legal || (c == OP_CSR && op.imm[19:18] > 2'(m));
		return d;
	endfunction

	// Mirrors the one-deep output register and counts items in and out
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			expDec <= '0;
			expVld <= 1'b0;
		end
		else if (!stall)
		begin
			expVld <= inVld;
			if (inVld)
			begin
				expDec <= refDecode(instr, om);
				acceptCount <= acceptCount + 1;
			end
		end
		// An item leaves when it is on the output and downstream is not stalled
		if (rstN && outVld && !stall)
			seenCount <= seenCount + 1;
	end

	task automatic reportMismatch(input string field, input logic [63:0] expVal,
		input logic [63:0] actVal);
		$display("MISMATCH %s expected %h actual %h", field, expVal, actVal);
		errCount++;
	endtask

	task automatic noteFailure(input string what);
		$display("%s", what);
		errCount++;
	endtask

	// ========================================================================
	// Checking assertions
	// ========================================================================

	assert property (@(posedge clk) disable iff (!rstN) outVld == expVld)
		else reportMismatch("outVld", 64'($sampled(expVld)), 64'($sampled(outVld)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.opcode == expDec.opcode)
		else reportMismatch("dec.opcode", 64'($sampled(expDec.opcode)),
			64'($sampled(dec.opcode)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rd == expDec.Rd)
		else reportMismatch("dec.Rd", 64'($sampled(expDec.Rd)), 64'($sampled(dec.Rd)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rdv == expDec.Rdv)
		else reportMismatch("dec.Rdv", 64'($sampled(expDec.Rdv)), 64'($sampled(dec.Rdv)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rs1 == expDec.Rs1)
		else reportMismatch("dec.Rs1", 64'($sampled(expDec.Rs1)), 64'($sampled(dec.Rs1)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rs1v == expDec.Rs1v)
		else reportMismatch("dec.Rs1v", 64'($sampled(expDec.Rs1v)), 64'($sampled(dec.Rs1v)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rs2 == expDec.Rs2)
		else reportMismatch("dec.Rs2", 64'($sampled(expDec.Rs2)), 64'($sampled(dec.Rs2)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.Rs2v == expDec.Rs2v)
		else reportMismatch("dec.Rs2v", 64'($sampled(expDec.Rs2v)), 64'($sampled(dec.Rs2v)));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.imm == expDec.imm)
		else reportMismatch("dec.imm", $sampled(expDec.imm), $sampled(dec.imm));
	assert property (@(posedge clk) disable iff (!rstN) outVld |-> dec.exc == expDec.exc)
		else reportMismatch("dec.exc", 64'($sampled(expDec.exc)), 64'($sampled(dec.exc)));
	// Back-pressure must leave the whole output register untouched
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(dec) && $stable(outVld))
		else noteFailure("output register changed while stall was high");

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic abortOnTimeout(input string what);
		errCount++;
		$display("timeout: %s after %0d cycles", what, TimeoutCycles);
		$display("*** FAILED ***");
		$finish;
	endtask

	function automatic micro_op_t randomOp();
		micro_op_t op;
		int idx;
		idx = int'($unsigned($random(seed)) % legalOps.size());
		op.opcode = legalOps[idx];
		op.Rd = 7'($random(seed));
		op.Rs1 = 7'($random(seed));
		op.Rs2 = 7'($random(seed));
		op.imm = 20'($random(seed));
		return op;
	endfunction

	function automatic bit isLegalCode(input logic [6:0] c);
		foreach (legalOps[i])
			if (legalOps[i] == c)
				return 1'b1;
		return 1'b0;
	endfunction

	// Holds one micro-op on the inputs until an edge accepts it
	task automatic sendOp(input micro_op_t op, input operating_mode_t m, input bit randStall);
		int waitCycles;
		bit taken;
		waitCycles = 0;
		taken = 1'b0;
		instr <= op;
		om <= m;
		inVld <= 1'b1;
		stall <= randStall && (($random(seed) & 3) == 0);
		while (!taken && waitCycles < TimeoutCycles)
		begin
			@(posedge clk);
			waitCycles++;
			if (inVld && !stall)
				taken = 1'b1;
			else
				stall <= randStall && (($random(seed) & 3) == 0);
		end
		if (!taken)
			abortOnTimeout("micro-op was never accepted");
	endtask

	// Sends a bubble and waits until the last item has left the output
	task automatic drainPipe(output int drainCycles);
		inVld <= 1'b0;
		stall <= 1'b0;
		drainCycles = 0;
		do
		begin
			@(negedge clk);
			drainCycles++;
		end
		while (outVld && drainCycles < TimeoutCycles);
		if (outVld)
			abortOnTimeout("outVld did not drop after a bubble");
		@(posedge clk);
	endtask

	task automatic finishTest(input string name, input int errStart);
		if (errCount == errStart)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d errors", name, errCount - errStart);
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		rstN <= 1'b0;
		inVld <= 1'b0;
		stall <= 1'b0;
		om <= OM_USER;
		instr <= '0;
		code = code.first();
		do
		begin
			legalOps.push_back(code);
			code = code.next();
		end
		while (code != code.first());
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		errBefore = errCount;
		@(negedge clk);
		assert (outVld == 1'b0) else reportMismatch("outVld", 64'h0, 64'(outVld));
		assert (dec == '0)
			else noteFailure($sformatf("MISMATCH dec expected 0 actual %h", dec));
		@(posedge clk);
		finishTest("reset", errBefore);

		// Every legal opcode once with random register fields
		errBefore = errCount;
		foreach (legalOps[i])
		begin
			uop = randomOp();
			uop.opcode = legalOps[i];
			sendOp(uop, OM_MACHINE, 1'b0);
		end
		drainPipe(cycles);
		finishTest("destination", errBefore);

		errBefore = errCount;
		repeat (200)
			sendOp(randomOp(), operating_mode_t'(2'($random(seed))), 1'b0);
		// Negative fields against each kind of extension
		uop = randomOp();
		uop.imm = 20'h80001;
		uop.opcode = OP_ADDI;
		sendOp(uop, OM_USER, 1'b0);
		uop.opcode = OP_ANDI;
		sendOp(uop, OM_USER, 1'b0);
		uop.imm = 20'hFFFFF;
		uop.opcode = OP_SHIFT;
		sendOp(uop, OM_USER, 1'b0);
		drainPipe(cycles);
		finishTest("source and immediate", errBefore);

		errBefore = errCount;
		for (int c = 0; c < 128; c++)
		begin
			if (!isLegalCode(7'(c)))
			begin
				uop = randomOp();
				uop.opcode = opcode_t'(7'(c));
				sendOp(uop, OM_MACHINE, 1'b0);
			end
		end
		// CSR privilege against each operating mode
		for (int p = 0; p < 4; p++)
		begin
			for (int m = 0; m < 4; m++)
			begin
				uop = randomOp();
				uop.opcode = OP_CSR;
				uop.imm[19:18] = 2'(p);
				sendOp(uop, operating_mode_t'(2'(m)), 1'b0);
			end
		end
		drainPipe(cycles);
		finishTest("exceptions", errBefore);

		errBefore = errCount;
		repeat (100)
			sendOp(randomOp(), operating_mode_t'(2'($random(seed))), 1'b1);
		drainPipe(cycles);
		assert (acceptCount == seenCount)
			else noteFailure($sformatf("%0d items accepted but %0d left the stage",
				acceptCount, seenCount));
		finishTest("latency and stall", errBefore);

		errBefore = errCount;
		repeat (10)
		begin
			sendOp(randomOp(), OM_USER, 1'b0);
			drainPipe(cycles);
			assert (cycles == 2)
				else noteFailure($sformatf("outVld stayed high %0d cycles after a bubble",
					cycles - 1));
		end
		finishTest("bubbles", errBefore);

		$display("tests passed %0d, tests failed %0d, check errors %0d", passCount, failCount,
			errCount);
		if (failCount == 0 && errCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* decodeStage.sv */
// Decode stage top level that joins the field decoders and registers the decoded record

`timescale 1ns/1ps

module decodeStage
	import decodePkg::*;
#(
	parameter int DataWidth = 64
)
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            inVld,
	input  logic            stall,
	input  operating_mode_t om,
	input  micro_op_t       instr,
	output logic            outVld,
	output decoded_t        dec
);

	// The decoded record has room for at most this many immediate bits
	if (DataWidth > MaxImmWidth)
	begin : gWidthCheck
		$error("decodeStage: DataWidth %0d exceeds %0d", DataWidth, MaxImmWidth);
	end

	// Combinational decoder results
	aregno_t              rd;
	logic                 rdv;
	logic                 exc;
	aregno_t              rs1;
	aregno_t              rs2;
	logic                 rs1v;
	logic                 rs2v;
	logic [DataWidth-1:0] immW;
	decoded_t             decNext;

	// ========================================================================
	// Field decoders
	// ========================================================================

	// Only the destination decoder needs the mode, for CSR privilege checks
	decodeDest destDec (
		.om    (om),
		.instr (instr),
		.Rd    (rd),
		.Rdv   (rdv),
		.exc   (exc)
	);

	decodeSrc srcDec (
		.instr (instr),
		.Rs1   (rs1),
		.Rs2   (rs2),
		.Rs1v  (rs1v),
		.Rs2v  (rs2v)
	);

	decodeImm #(
		.DataWidth (DataWidth)
	) immDec (
		.instr (instr),
		.imm   (immW)
	);

	// Gather the fields, upper immediate bits above DataWidth stay zero
	always_comb
	begin
		decNext = '0;
		decNext.opcode = instr.opcode;
		decNext.Rd = rd;
		decNext.Rdv = rdv;
		decNext.Rs1 = rs1;
		decNext.Rs1v = rs1v;
		decNext.Rs2 = rs2;
		decNext.Rs2v = rs2v;
		decNext.imm[DataWidth-1:0] = immW;
		decNext.exc = exc;
	end

	// ========================================================================
	// Output register
	// ========================================================================

	// Stall freezes everything, a bubble only drops the valid level
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outVld <= 1'b0;
			dec <= '0;
		end
		else if (!stall)
		begin
			outVld <= inVld;
			if (inVld)
				dec <= decNext;
		end
	end

	// Upstream relies on a stalled output holding its item untouched
	assert property (@(posedge clk) rstN && stall |=> $stable(dec) && $stable(outVld))
		else $error("decodeStage: output changed during stall");

	assert property (@(posedge clk) !rstN |=> !outVld)
		else $error("decodeStage: outVld high after reset");

endmodule

/* decodeImm.sv */
// Immediate extractor that sign- or zero-extends the micro-op field to the data width

`timescale 1ns/1ps

module decodeImm
	import decodePkg::*;
#(
	parameter int DataWidth = 64
)
(
	input  micro_op_t              instr,
	output logic [DataWidth-1:0]   imm
);

	// The full raw field must fit, narrower paths would drop immediate bits
	if (DataWidth < ImmFieldWidth)
	begin : gWidthCheck
		$error("decodeImm: DataWidth %0d is below the %0d-bit field", DataWidth,
			ImmFieldWidth);
	end

	// Both extensions of the raw field, picked below by opcode
	logic [DataWidth-1:0] immSext;
	logic [DataWidth-1:0] immZext;
	logic [DataWidth-1:0] shiftAmt;

	assign immSext = DataWidth'(signed'(instr.imm));
	assign immZext = DataWidth'(instr.imm);
	// Shift amounts only ever use the low seven bits
	assign shiftAmt = DataWidth'(instr.imm[6:0]);

	// ========================================================================
	// Extension select
	// ========================================================================

	always_comb
	begin
		case (instr.opcode)
		// Logical and unsigned ops treat the field as unsigned
		OP_ANDI, OP_ORI, OP_XORI, OP_CMPUI, OP_MULUI, OP_DIVUI, OP_CSR:
			imm = immZext;
		OP_SHIFT:
			imm = shiftAmt;
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ,
		OP_BSR, OP_JSR,
		OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ,
		OP_LOAD, OP_LOADA, OP_LDV,
		OP_STB, OP_STW, OP_STORE,
		OP_AMO, OP_CMPSWAP:
			imm = immSext;
		// NOP and illegal codes carry no immediate
		default:
			imm = '0;
		endcase
	end

endmodule

/* decodeSrc.sv */
// Source register decoder for the two read ports of a micro-op

`timescale 1ns/1ps

module decodeSrc
	import decodePkg::*;
(
	input  micro_op_t instr,
	output aregno_t   Rs1,
	output aregno_t   Rs2,
	output logic      Rs1v,
	output logic      Rs2v
);

	// Unread sources report register zero so the rename stage skips them

	// ========================================================================
	// First source
	// ========================================================================

	// Everything that takes a base or an operand reads Rs1
	always_comb
	begin
		case (instr.opcode)
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_CMPUI, OP_ANDI, OP_ORI, OP_XORI,
		OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_SHIFT,
		OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ,
		OP_JSR,
		OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ,
		OP_LOAD, OP_LOADA, OP_LDV,
		OP_STB, OP_STW, OP_STORE,
		OP_AMO, OP_CMPSWAP:
		begin
			Rs1 = instr.Rs1;
			Rs1v = VAL;
		end
		// CSR and BSR take only the immediate
		default:
		begin
			Rs1 = '0;
			Rs1v = INV;
		end
		endcase
	end

	// ========================================================================
	// Second source
	// ========================================================================

	// Rs2 is the second float operand, the store data or the atomic operand
	always_comb
	begin
		case (instr.opcode)
		OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ,
		OP_STB, OP_STW, OP_STORE,
		OP_AMO, OP_CMPSWAP:
		begin
			Rs2 = instr.Rs2;
			Rs2v = VAL;
		end
		default:
		begin
			Rs2 = '0;
			Rs2v = INV;
		end
		endcase
	end

	// Neither port may name a register it does not read
	always_comb
	begin
		if (Rs1v == INV)
			assert (Rs1 == '0) else $error("decodeSrc: Rs1 %0h while invalid", Rs1);
		if (Rs2v == INV)
			assert (Rs2 == '0) else $error("decodeSrc: Rs2 %0h while invalid", Rs2);
	end

endmodule

/* decodeDest.sv */
// Destination register decoder that also flags illegal opcodes and CSR privilege faults

`timescale 1ns/1ps

module decodeDest
	import decodePkg::*;
(
	input  operating_mode_t om,
	input  micro_op_t       instr,
	output aregno_t         Rd,
	output logic            Rdv,
	output logic            exc
);

	// Privilege level required by a CSR access, top two bits of the immediate
	logic [1:0] csrPriv;

	assign csrPriv = instr.imm[ImmFieldWidth-1 -: 2];

	// ========================================================================
	// Destination and exception decode
	// ========================================================================

	always_comb
	begin
		// Default covers stores, NOP and anything not listed
		Rd = '0;
		Rdv = INV;
		exc = 1'b0;
		case (instr.opcode)
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_CMPUI, OP_ANDI, OP_ORI, OP_XORI,
		OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_SHIFT,
		OP_FLTH, OP_FLTS, OP_FLTD, OP_FLTQ,
		OP_BSR, OP_JSR,
		OP_LDB, OP_LDBZ, OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ,
		OP_LOAD, OP_LOADA, OP_LDV,
		OP_AMO, OP_CMPSWAP:
		begin
			Rd = instr.Rd;
			Rdv = VAL;
		end
		OP_CSR:
		begin
			// A CSR read still names its target, the fault travels with it
			Rd = instr.Rd;
			Rdv = VAL;
			exc = (csrPriv > 2'(om));
		end
		// Stores and NOP write nothing and are legal
		OP_STB, OP_STW, OP_STORE, OP_NOP:
		begin
			Rd = '0;
			Rdv = INV;
		end
		default:
			exc = 1'b1;
		endcase
	end

	// A register that is not written must read as register zero downstream
	always_comb
	begin
		if (Rdv == INV)
			assert (Rd == '0)
				else $error("decodeDest: Rd %0h reported while Rdv is invalid", Rd);
	end

endmodule

/* decodePkg.sv */
// Decode stage package with opcodes, operating modes, the micro-op record and the decoded record

package decodePkg;

	// ========================================================================
	// Widths and constants
	// ========================================================================

	// Width of the raw immediate field carried in every micro-op
	localparam int ImmFieldWidth = 20;

	// Widest immediate the decoded record can hold
	localparam int MaxImmWidth = 64;

	// Valid and invalid markers for register fields
	localparam logic VAL = 1'b1;
	localparam logic INV = 1'b0;

	// Architectural register number, register zero stands for no register
	typedef logic [6:0] aregno_t;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// The encodings leave gaps on purpose, every unlisted code is illegal
	typedef enum logic [6:0] {
		OP_NOP     = 7'h00,
		// ALU with immediate
		OP_ADDI    = 7'h04,
		OP_SUBFI   = 7'h05,
		OP_CMPI    = 7'h06,
		OP_CMPUI   = 7'h07,
		OP_ANDI    = 7'h08,
		OP_ORI     = 7'h09,
		OP_XORI    = 7'h0A,
		OP_MULI    = 7'h0C,
		OP_MULUI   = 7'h0D,
		OP_DIVI    = 7'h0E,
		OP_DIVUI   = 7'h0F,
		OP_SHIFT   = 7'h10,
		// Floating point, one opcode per precision
		OP_FLTH    = 7'h18,
		OP_FLTS    = 7'h19,
		OP_FLTD    = 7'h1A,
		OP_FLTQ    = 7'h1B,
		// System and flow control
		OP_CSR     = 7'h20,
		OP_BSR     = 7'h24,
		OP_JSR     = 7'h25,
		// Loads, the Z forms zero-extend the loaded value
		OP_LDB     = 7'h40,
		OP_LDBZ    = 7'h41,
		OP_LDW     = 7'h42,
		OP_LDWZ    = 7'h43,
		OP_LDT     = 7'h44,
		OP_LDTZ    = 7'h45,
		OP_LOAD    = 7'h46,
		OP_LOADA   = 7'h47,
		OP_LDV     = 7'h48,
		// Stores
		OP_STB     = 7'h50,
		OP_STW     = 7'h51,
		OP_STORE   = 7'h52,
		// Atomic memory operations
		OP_AMO     = 7'h60,
		OP_CMPSWAP = 7'h61
	} opcode_t;

	// Operating modes in rising order of privilege
	typedef enum logic [1:0] {
		OM_USER       = 2'd0,
		OM_SUPERVISOR = 2'd1,
		OM_HYPERVISOR = 2'd2,
		OM_MACHINE    = 2'd3
	} operating_mode_t;

	// ========================================================================
	// Records
	// ========================================================================

	// Fixed-format micro-op, 48 bits; for OP_CSR imm[19:18] is the CSR privilege
	typedef struct packed {
		opcode_t                  opcode;
		aregno_t                  Rd;
		aregno_t                  Rs1;
		aregno_t                  Rs2;
		logic [ImmFieldWidth-1:0] imm;
	} micro_op_t;

	// Decoded record, imm sized for the widest data path
	typedef struct packed {
		opcode_t                opcode;
		aregno_t                Rd;
		logic                   Rdv;
		aregno_t                Rs1;
		logic                   Rs1v;
		aregno_t                Rs2;
		logic                   Rs2v;
		logic [MaxImmWidth-1:0] imm;
		logic                   exc;
	} decoded_t;

endpackage
